/* Bender.yml */
package:
  name: board_io

sources:
  - logic/io_map_pkg.sv
  - logic/uart_pkg.sv
  - logic/io_bus_if.sv
  - logic/apb_io_bridge.sv
  - logic/io_register_file.sv
  - logic/uart_transmitter.sv
  - logic/board_io_top.sv
  - target: simulation
    files:
      - verification/board_io_tb.sv

/* logic/apb_io_bridge.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB to I/O bus bridge
// Zero wait state slave
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module apb_io_bridge import io_map_pkg::*;
(
	input logic clk,
	input logic reset,

	// APB slave
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [ADDR_WIDTH-1:0] paddr,
	input logic [DATA_WIDTH-1:0] pwdata,
	output logic [DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// To register file
	io_bus_if.bridge io
);

	logic setup_phase;
	logic access_phase;

	// Phase classification
	assign setup_phase = psel && !penable;
	assign access_phase = psel && penable;

	// Reads go out early so data is registered by the access phase
	// Writes go out in the access phase when the transfer commits
	always_comb
	begin
		if (setup_phase && !pwrite)
			io.op = IO_READ;
		else if (access_phase && pwrite)
			io.op = IO_WRITE;
		else
			io.op = IO_IDLE;
	end

	assign io.address = paddr;	// Held stable across both phases
	assign io.write_data = pwdata;

	// Read data already registered on the setup edge
	assign prdata = io.read_data;
	assign pready = 1'b1;	// Never stalls

	// Error only reported while the transfer completes
	assign pslverr = access_phase && io.decode_error;

	// Protocol checks on the master
	penable_needs_psel: assert property (
		@(posedge clk) disable iff (reset)
		$rose(penable) |-> psel
	) else $error("penable rose without psel");

	paddr_stable: assert property (
		@(posedge clk) disable iff (reset)
		(access_phase && $past(setup_phase)) |-> $stable(paddr)
	) else $error("paddr changed between setup and access");

endmodule

`default_nettype wire

/* logic/board_io_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O subsystem
// APB slave for LEDs, digits and UART
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module board_io_top import io_map_pkg::*, uart_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// APB slave
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [ADDR_WIDTH-1:0] paddr,
	input wire logic [DATA_WIDTH-1:0] pwdata,
	output logic [DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// Board pins
	output logic [RED_LED_WIDTH-1:0] red_led,
	output logic [GREEN_LED_WIDTH-1:0] green_led,
	output logic [HEX_WIDTH-1:0] hex0,
	output logic [HEX_WIDTH-1:0] hex1,
	output logic [HEX_WIDTH-1:0] hex2,
	output logic [HEX_WIDTH-1:0] hex3,
	output logic uart_tx
);

	// Register file to transmitter
	logic tx_load;
	logic [UART_DATA_BITS-1:0] tx_byte;
	logic tx_busy;

	io_bus_if io_bus();

	apb_io_bridge apb_io_bridge(
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.io(io_bus.bridge));

	io_register_file io_register_file(
		.clk(clk),
		.reset(reset),
		.io(io_bus.regs),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.tx_load(tx_load),
		.tx_byte(tx_byte),
		.tx_busy(tx_busy));

	uart_transmitter uart_transmitter(
		.clk(clk),
		.reset(reset),
		.tx_load(tx_load),
		.tx_byte(tx_byte),
		.tx_busy(tx_busy),
		.uart_tx(uart_tx));

endmodule

`default_nettype wire

/* logic/io_bus_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal I/O bus
// Single-cycle ops from bridge to registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface io_bus_if import io_map_pkg::*; ();

	io_op_t op;	// One cycle per transfer
	logic [ADDR_WIDTH-1:0] address;
	logic [DATA_WIDTH-1:0] write_data;
	logic [DATA_WIDTH-1:0] read_data;	// Registered in register file
	logic decode_error;	// Unmapped address

	// Bus master side
	modport bridge
	(
		output op,
		output address,
		output write_data,
		input read_data,
		input decode_error
	);

	// Register file side
	modport regs
	(
		input op,
		input address,
		input write_data,
		output read_data,
		output decode_error
	);

endinterface

`default_nettype wire

/* logic/io_map_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O register map
// Offsets, widths and bus operation codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package io_map_pkg;

	// Bus geometry
	localparam int ADDR_WIDTH = 8;	// Byte address
	localparam int DATA_WIDTH = 32;

	// Register offsets
	localparam logic [ADDR_WIDTH-1:0] RED_LED_ADDR = 8'h00;
	localparam logic [ADDR_WIDTH-1:0] GREEN_LED_ADDR = 8'h04;
	localparam logic [ADDR_WIDTH-1:0] HEX0_ADDR = 8'h08;
	localparam logic [ADDR_WIDTH-1:0] HEX1_ADDR = 8'h0c;
	localparam logic [ADDR_WIDTH-1:0] HEX2_ADDR = 8'h10;
	localparam logic [ADDR_WIDTH-1:0] HEX3_ADDR = 8'h14;
	localparam logic [ADDR_WIDTH-1:0] UART_DATA_ADDR = 8'h18;	// Write only
	localparam logic [ADDR_WIDTH-1:0] UART_STATUS_ADDR = 8'h1c;	// Bit 0 is busy

	// Register widths
	localparam int RED_LED_WIDTH = 18;
	localparam int GREEN_LED_WIDTH = 9;
	localparam int HEX_WIDTH = 7;

	// Segments are active low so all ones blanks a digit
	localparam logic [HEX_WIDTH-1:0] HEX_RESET_VALUE = 7'b1111111;

	// Operation on the internal I/O bus
	typedef enum logic [1:0]
	{
		IO_IDLE,
		IO_READ,	// Issued in APB setup phase
		IO_WRITE	// Issued in APB access phase
	} io_op_t;

endpackage

`default_nettype wire

/* logic/io_register_file.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O register file
// LED and digit registers plus UART launch
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module io_register_file import io_map_pkg::*, uart_pkg::*;
(
	input logic clk,
	input logic reset,
	io_bus_if.regs io,

	// Board outputs
	output logic [RED_LED_WIDTH-1:0] red_led,
	output logic [GREEN_LED_WIDTH-1:0] green_led,
	output logic [HEX_WIDTH-1:0] hex0,
	output logic [HEX_WIDTH-1:0] hex1,
	output logic [HEX_WIDTH-1:0] hex2,
	output logic [HEX_WIDTH-1:0] hex3,

	// Transmitter handshake
	output logic tx_load,
	output logic [UART_DATA_BITS-1:0] tx_byte,
	input logic tx_busy
);

	logic address_hit;
	logic [DATA_WIDTH-1:0] read_value;
	logic [DATA_WIDTH-1:0] read_data_q;
	logic read_error_q;

	// Address decode and read mux
	always_comb
	begin
		address_hit = 1'b1;
		read_value = '0;
		case (io.address)
			RED_LED_ADDR: read_value = DATA_WIDTH'(red_led);
			GREEN_LED_ADDR: read_value = DATA_WIDTH'(green_led);
			HEX0_ADDR: read_value = DATA_WIDTH'(hex0);
			HEX1_ADDR: read_value = DATA_WIDTH'(hex1);
			HEX2_ADDR: read_value = DATA_WIDTH'(hex2);
			HEX3_ADDR: read_value = DATA_WIDTH'(hex3);
			UART_DATA_ADDR: read_value = '0;	// Write only
			UART_STATUS_ADDR: read_value = DATA_WIDTH'(tx_busy);
			default: address_hit = 1'b0;	// Unmapped
		endcase
	end

	// Display register writes
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			red_led <= '0;
			green_led <= '0;
			hex0 <= HEX_RESET_VALUE;
			hex1 <= HEX_RESET_VALUE;
			hex2 <= HEX_RESET_VALUE;
			hex3 <= HEX_RESET_VALUE;
		end
		else if (io.op == IO_WRITE)
		begin
			case (io.address)
				RED_LED_ADDR: red_led <= io.write_data[RED_LED_WIDTH-1:0];
				GREEN_LED_ADDR: green_led <= io.write_data[GREEN_LED_WIDTH-1:0];
				HEX0_ADDR: hex0 <= io.write_data[HEX_WIDTH-1:0];
				HEX1_ADDR: hex1 <= io.write_data[HEX_WIDTH-1:0];
				HEX2_ADDR: hex2 <= io.write_data[HEX_WIDTH-1:0];
				HEX3_ADDR: hex3 <= io.write_data[HEX_WIDTH-1:0];
				default: ;	// Status and unmapped writes dropped
			endcase
		end
	end

	// Read data captured in setup phase and cleared otherwise
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_data_q <= '0;
			read_error_q <= 1'b0;
		end
		else if (io.op == IO_READ)
		begin
			read_data_q <= read_value;	// Zero on a miss
			read_error_q <= !address_hit;
		end
		else
		begin
			read_data_q <= '0;
			read_error_q <= 1'b0;
		end
	end

	assign io.read_data = read_data_q;

	// Write errors decoded live during the access phase
	assign io.decode_error = (io.op == IO_WRITE) ? !address_hit : read_error_q;

	// Byte is dropped if the transmitter is still busy
	assign tx_load = (io.op == IO_WRITE) && (io.address == UART_DATA_ADDR) && !tx_busy;
	assign tx_byte = io.write_data[UART_DATA_BITS-1:0];

	// Transmitter must take the byte on the next edge
	busy_after_load: assert property (
		@(posedge clk) disable iff (reset)
		tx_load |=> tx_busy
	) else $error("tx_busy not raised after tx_load");

endmodule

`default_nettype wire

/* logic/uart_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial line constants
// Baud timing and transmitter states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package uart_pkg;

	localparam int BAUD_DIVIDE = 16;	// Clocks per bit
	localparam int UART_DATA_BITS = 8;

	// Counter widths
	localparam int BAUD_COUNT_WIDTH = $clog2(BAUD_DIVIDE);
	localparam int BIT_COUNT_WIDTH = $clog2(UART_DATA_BITS);

	// 8N1 frame sequence
	typedef enum logic [1:0]
	{
		TX_IDLE,	// Line high
		TX_START,	// One low bit
		TX_DATA,	// LSB first
		TX_STOP		// One high bit
	} uart_state_t;

endpackage

`default_nettype wire

/* logic/uart_transmitter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART transmitter
// 8N1 serializer with fixed baud divide
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter import uart_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic tx_load,	// One cycle start pulse
	input logic [UART_DATA_BITS-1:0] tx_byte,
	output logic tx_busy,
	output logic uart_tx	// Serial line, idles high
);

	uart_state_t state_q;
	logic [BAUD_COUNT_WIDTH-1:0] baud_count;
	logic [BIT_COUNT_WIDTH-1:0] bit_count;
	logic [UART_DATA_BITS-1:0] shift_q;	// Latched byte
	logic baud_done;
	logic last_bit;
	logic next_bit;

	assign baud_done = baud_count == BAUD_COUNT_WIDTH'(BAUD_DIVIDE - 1);
	assign last_bit = bit_count == BIT_COUNT_WIDTH'(UART_DATA_BITS - 1);

	// Moving on to a data bit
	assign next_bit = baud_done && ((state_q == TX_START)
		|| (state_q == TX_DATA && !last_bit));

	// Frame sequencing
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_q <= TX_IDLE;
			baud_count <= '0;
			bit_count <= '0;
			uart_tx <= 1'b1;
		end
		else
		begin
			case (state_q)
				TX_IDLE:
				begin
					if (tx_load)
					begin
						state_q <= TX_START;
						baud_count <= '0;
						uart_tx <= 1'b0;	// Start bit
					end
				end

				TX_START:
				begin
					baud_count <= baud_count + 1'b1;	// Wraps at divide
					if (baud_done)
					begin
						state_q <= TX_DATA;
						bit_count <= '0;
						uart_tx <= shift_q[0];
					end
				end

				TX_DATA:
				begin
					baud_count <= baud_count + 1'b1;
					if (baud_done)
					begin
						if (last_bit)
						begin
							state_q <= TX_STOP;
							uart_tx <= 1'b1;	// Stop bit
						end
						else
						begin
							bit_count <= bit_count + 1'b1;
							uart_tx <= shift_q[0];
						end
					end
				end

				TX_STOP:
				begin
					baud_count <= baud_count + 1'b1;
					if (baud_done)
						state_q <= TX_IDLE;	// Line already high
				end

				default: state_q <= TX_IDLE;
			endcase
		end
	end

	// Byte shifter, LSB leaves first
	always_ff @(posedge clk)
	begin
		if (state_q == TX_IDLE && tx_load)
			shift_q <= tx_byte;
		else if (next_bit)
			shift_q <= shift_q >> 1;
	end

	assign tx_busy = state_q != TX_IDLE;

	// Line must rest high between frames
	idle_line_high: assert property (
		@(posedge clk) disable iff (reset)
		(state_q == TX_IDLE) |-> uart_tx
	) else $error("uart_tx low while idle");

endmodule

`default_nettype wire

/* verification/board_io_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O subsystem testbench
// APB driver, register model, UART monitor
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module board_io_tb import io_map_pkg::*, uart_pkg::*;
();

	// Run length budget for the watchdog
	localparam int TRANSFER_COUNT = 7 + 200 + 40 + 40 + 20 * 2 + 4;
	localparam int BYTE_COUNT = 21;
	localparam int MARGIN_CYCLES = 3000;	// Status polling and idle cycles
	localparam int TIMEOUT_CYCLES = TRANSFER_COUNT * 2
		+ BYTE_COUNT * 10 * BAUD_DIVIDE + MARGIN_CYCLES;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ADDR_WIDTH-1:0] paddr;
	logic [DATA_WIDTH-1:0] pwdata;
	logic [DATA_WIDTH-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [RED_LED_WIDTH-1:0] red_led;
	logic [GREEN_LED_WIDTH-1:0] green_led;
	logic [HEX_WIDTH-1:0] hex0;
	logic [HEX_WIDTH-1:0] hex1;
	logic [HEX_WIDTH-1:0] hex2;
	logic [HEX_WIDTH-1:0] hex3;
	logic uart_tx;

	logic [DATA_WIDTH-1:0] model_regs [0:5];	// Red, green, hex0 to hex3
	logic [7:0] sent_bytes [$];	// Accepted by the DUT
	logic [7:0] line_bytes [$];	// Seen on the serial line
	int pass_count;
	int fail_count;
	int test_fail_base;

	board_io_top UUT(
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.uart_tx(uart_tx));

	always #5 clk = !clk;	// 10 ns period

	// Width of each display register by map index
	function automatic int reg_width(input int index);
		if (index == 0)
			return RED_LED_WIDTH;
		else if (index == 1)
			return GREEN_LED_WIDTH;
		else
			return HEX_WIDTH;
	endfunction

	// Map holds eight word registers from 0x00 to 0x1c
	function automatic logic is_mapped(input logic [ADDR_WIDTH-1:0] addr);
		return (addr <= 8'h1c) && (addr[1:0] == 2'b00);
	endfunction

	task automatic check(input logic [DATA_WIDTH-1:0] actual,
		input logic [DATA_WIDTH-1:0] expected, input string msg);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
			fail_count++;
		end
		else
			pass_count++;
	endtask

	// One APB write, setup then access
	task automatic apb_write(input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		check(DATA_WIDTH'(pready), 32'h1, "write pready");
		err = pslverr;	// Mid access phase
		@(posedge clk);	// Write commits here
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	// One APB read, data sampled mid access
	task automatic apb_read(input logic [ADDR_WIDTH-1:0] addr,
		output logic [DATA_WIDTH-1:0] data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready)
			@(negedge clk);
		check(DATA_WIDTH'(pready), 32'h1, "read pready");
		data = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// All six display outputs against the model
	task automatic check_outputs(input string msg);
		@(negedge clk);
		check(DATA_WIDTH'(red_led), model_regs[0], {msg, " red_led"});
		check(DATA_WIDTH'(green_led), model_regs[1], {msg, " green_led"});
		check(DATA_WIDTH'(hex0), model_regs[2], {msg, " hex0"});
		check(DATA_WIDTH'(hex1), model_regs[3], {msg, " hex1"});
		check(DATA_WIDTH'(hex2), model_regs[4], {msg, " hex2"});
		check(DATA_WIDTH'(hex3), model_regs[5], {msg, " hex3"});
	endtask

	// Poll status until the transmitter is free
	task automatic wait_tx_idle();
		logic [DATA_WIDTH-1:0] status;
		logic err;
		status = 32'h1;
		while (status[0])
			apb_read(UART_STATUS_ADDR, status, err);
	endtask

	// Sent and received bytes in order, queues drained
	task automatic compare_bytes(input string msg);
		check(line_bytes.size(), sent_bytes.size(), {msg, " byte count"});
		while (line_bytes.size() > 0 && sent_bytes.size() > 0)
			check(line_bytes.pop_front(), sent_bytes.pop_front(), {msg, " byte value"});
		line_bytes.delete();
		sent_bytes.delete();
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d failures", name, fail_count - test_fail_base);
		test_fail_base = fail_count;
	endtask

	// Serial monitor, samples mid bit
	initial
	begin
		logic [7:0] rx_byte;
		wait (reset === 1'b0);
		forever
		begin
			@(negedge uart_tx);
			repeat (BAUD_DIVIDE / 2) @(negedge clk);
			check(DATA_WIDTH'(uart_tx), 32'h0, "serial start bit");
			for (int i = 0; i < UART_DATA_BITS; i++)
			begin
				repeat (BAUD_DIVIDE) @(negedge clk);
				rx_byte[i] = uart_tx;	// LSB first
			end
			repeat (BAUD_DIVIDE) @(negedge clk);
			check(DATA_WIDTH'(uart_tx), 32'h1, "serial stop bit");
			line_bytes.push_back(rx_byte);
		end
	end

	// Watchdog
	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("The run timed out after %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		logic [DATA_WIDTH-1:0] data;
		logic [ADDR_WIDTH-1:0] addr;
		logic err;
		int index;
		logic [7:0] tx_value;

		void'($urandom(32'h4dbc));
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pass_count = 0;
		fail_count = 0;
		test_fail_base = 0;
		model_regs[0] = '0;
		model_regs[1] = '0;
		for (int i = 2; i < 6; i++)
			model_regs[i] = DATA_WIDTH'(HEX_RESET_VALUE);	// Digits blank

		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Reset values on pins and through the bus
		check_outputs("reset");
		check(DATA_WIDTH'(uart_tx), 32'h1, "reset uart_tx");
		for (int i = 0; i < 6; i++)
		begin
			apb_read(ADDR_WIDTH'(i * 4), data, err);
			check(data, model_regs[i], "reset readback");
		end
		apb_read(UART_STATUS_ADDR, data, err);
		check(data, 32'h0, "reset status");
		end_test("Reset values");

		// Random display writes
		for (int n = 0; n < 200; n++)
		begin
			index = $urandom_range(5);
			data = $urandom();
			apb_write(ADDR_WIDTH'(index * 4), data, err);
			model_regs[index] = data & ((32'h1 << reg_width(index)) - 1);	// Truncate
			check(DATA_WIDTH'(err), 32'h0, "write pslverr");
			check_outputs("random write");
		end
		end_test("Random register writes");

		// Readback, zero-extended
		for (int n = 0; n < 40; n++)
		begin
			index = $urandom_range(5);
			apb_read(ADDR_WIDTH'(index * 4), data, err);
			check(data, model_regs[index], "readback data");
			check(DATA_WIDTH'(err), 32'h0, "readback pslverr");
		end
		end_test("Readback");

		// Unmapped addresses, alternating write and read
		for (int n = 0; n < 40; n++)
		begin
			do
				addr = ADDR_WIDTH'($urandom_range(255));
			while (is_mapped(addr));
			if (n % 2 == 0)
				apb_write(addr, $urandom(), err);
			else
			begin
				apb_read(addr, data, err);
				check(data, 32'h0, "unmapped read data");
			end
			check(DATA_WIDTH'(err), 32'h1, "unmapped pslverr");
			check_outputs("unmapped access");
		end
		end_test("Unmapped addresses");

		// UART bytes, polled one at a time
		for (int n = 0; n < 20; n++)
		begin
			tx_value = 8'($urandom());
			wait_tx_idle();
			apb_write(UART_DATA_ADDR, DATA_WIDTH'(tx_value), err);
			sent_bytes.push_back(tx_value);
			apb_read(UART_STATUS_ADDR, data, err);
			check(data, 32'h1, "status after write");
		end
		wait_tx_idle();	// Last stop bit already sampled
		compare_bytes("uart");
		end_test("UART bytes");

		// Second write during a frame is dropped
		wait_tx_idle();
		tx_value = 8'($urandom());
		apb_write(UART_DATA_ADDR, DATA_WIDTH'(tx_value), err);
		sent_bytes.push_back(tx_value);
		apb_read(UART_STATUS_ADDR, data, err);
		check(data, 32'h1, "status busy");
		apb_write(UART_DATA_ADDR, DATA_WIDTH'(~tx_value), err);	// Busy, not accepted
		wait_tx_idle();
		repeat (10 * BAUD_DIVIDE) @(negedge clk);	// One frame of quiet line
		compare_bytes("busy drop");
		end_test("Busy drop");

		$display("Checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
logic/io_map_pkg.sv
logic/uart_pkg.sv
logic/io_bus_if.sv
logic/apb_io_bridge.sv
logic/io_register_file.sv
logic/uart_transmitter.sv
logic/board_io_top.sv
verification/board_io_tb.sv
